// File: verilog/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;

    // base opcodes of the supported subset
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OPIMM  = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_STORE  = 7'b0100011;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic {SRC1_RS1, SRC1_PC} alu_src1_sel_t;
    typedef enum logic {SRC2_RS2, SRC2_IMM} alu_src2_sel_t;
    typedef enum logic [1:0] {CMP_NONE, CMP_EQ, CMP_NE} cmp_op_t;
    typedef enum logic {WB_ALU, WB_PC4} wb_data_sel_t;

    typedef struct packed {
        logic  valid;
        data_t pc;
        data_t instr;
    } if_id_t;

    typedef struct packed {
        logic          valid;
        data_t         pc;
        data_t         pc_next;
        data_t         rs1_data;
        data_t         rs2_data;
        data_t         imm;
        reg_addr_t     rd;
        reg_addr_t     rs1;
        reg_addr_t     rs2;
        // execute control
        logic          jump;
        logic          branch;
        alu_src1_sel_t alu_src1_sel;
        alu_src2_sel_t alu_src2_sel;
        alu_op_t       alu_op;
        cmp_op_t       cmp_op;
        // store and writeback control
        logic          mem_write;
        logic          reg_write;
        wb_data_sel_t  wb_data_sel;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        data_t     pc;
        reg_addr_t rd;
        logic      reg_write;
        data_t     wdata;
        logic      mem_write;
        data_t     store_addr;
        data_t     store_data;
    } ex_wb_t;

    // one retired instruction as seen on the commit port
    typedef ex_wb_t retire_t;

    localparam if_id_t IF_ID_BUBBLE = '0;
    localparam ex_wb_t EX_WB_BUBBLE = '0;

    localparam id_ex_t ID_EX_BUBBLE = '{
        valid:        1'b0,
        pc:           '0,
        pc_next:      '0,
        rs1_data:     '0,
        rs2_data:     '0,
        imm:          '0,
        rd:           '0,
        rs1:          '0,
        rs2:          '0,
        jump:         1'b0,
        branch:       1'b0,
        alu_src1_sel: SRC1_RS1,
        alu_src2_sel: SRC2_RS2,
        alu_op:       ALU_ADD,
        cmp_op:       CMP_NONE,
        mem_write:    1'b0,
        reg_write:    1'b0,
        wb_data_sel:  WB_ALU
    };

endpackage

// File: verilog/pipe_reg.sv
module pipe_reg #(
    parameter type      payload_t = logic [31:0],
    parameter payload_t BUBBLE    = '0
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     stall_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t q;

    // flush wins over stall, reset behaves like a flush
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            q <= BUBBLE;
        end else if (!stall_i) begin
            q <= d_i;
        end
    end

    assign q_o = q;

endmodule

// File: verilog/fetch_unit.sv
module fetch_unit #(
    parameter cpu_pkg::data_t RESET_PC = '0
) (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             stall_i,
    input  logic             redirect_i,
    input  cpu_pkg::data_t   target_i,
    input  cpu_pkg::data_t   imem_data_i,
    output cpu_pkg::data_t   imem_addr_o,
    output cpu_pkg::if_id_t  if_o
);

    import cpu_pkg::*;

    data_t pc_q;

    // redirect target beats sequential advance
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= target_i;
        end else if (!stall_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // word index into instruction memory
    assign imem_addr_o = {2'b00, pc_q[31:2]};

    assign if_o.valid = !stall_i;
    assign if_o.pc    = pc_q;
    assign if_o.instr = imem_data_i;

endmodule

// File: verilog/hazard_ctrl.sv
module hazard_ctrl (
    input  logic imem_ready_i,
    input  logic redirect_i,
    output logic fetch_stall_o,
    output logic if_id_stall_o,
    output logic if_id_flush_o,
    output logic id_ex_flush_o
);

    logic imem_wait;

    assign imem_wait = !imem_ready_i;

    // pc keeps moving on a redirect even while memory waits
    assign fetch_stall_o = imem_wait && !redirect_i;

    // decode holds its instruction until fetch can move again
    assign if_id_stall_o = imem_wait;

    // wrong-path instruction in decode dies on a taken branch
    assign if_id_flush_o = redirect_i;

    // a held decode slot must not enter execute twice, so feed a bubble
    assign id_ex_flush_o = redirect_i || imem_wait;

endmodule

// File: verilog/decoder.sv
module decoder (
    input  cpu_pkg::if_id_t   if_i,
    input  cpu_pkg::data_t    rs1_data_i,
    input  cpu_pkg::data_t    rs2_data_i,
    output cpu_pkg::reg_addr_t rs1_o,
    output cpu_pkg::reg_addr_t rs2_o,
    output cpu_pkg::id_ex_t   id_o
);

    import cpu_pkg::*;

    opcode_t   opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    data_t     imm_i;
    data_t     imm_s;
    data_t     imm_b;
    data_t     imm_u;
    data_t     imm_j;
    alu_op_t   op_alu;
    logic      op_legal;
    logic      legal;

    assign opcode = if_i.instr[6:0];
    assign funct3 = if_i.instr[14:12];
    assign funct7 = if_i.instr[31:25];
    assign rs1_o  = if_i.instr[19:15];
    assign rs2_o  = if_i.instr[24:20];

    assign imm_i = {{20{if_i.instr[31]}}, if_i.instr[31:20]};
    assign imm_s = {{20{if_i.instr[31]}}, if_i.instr[31:25], if_i.instr[11:7]};
    assign imm_b = {{19{if_i.instr[31]}}, if_i.instr[31], if_i.instr[7],
                    if_i.instr[30:25], if_i.instr[11:8], 1'b0};
    assign imm_u = {if_i.instr[31:12], 12'b0};
    assign imm_j = {{11{if_i.instr[31]}}, if_i.instr[31], if_i.instr[19:12],
                    if_i.instr[20], if_i.instr[30:21], 1'b0};

    // register-register ops, keyed on funct7 and funct3
    always_comb begin
        op_legal = 1'b1;
        op_alu   = ALU_ADD;
        case ({funct7, funct3})
            10'b0000000_000: op_alu = ALU_ADD;
            10'b0100000_000: op_alu = ALU_SUB;
            10'b0000000_111: op_alu = ALU_AND;
            10'b0000000_110: op_alu = ALU_OR;
            10'b0000000_100: op_alu = ALU_XOR;
            10'b0000000_010: op_alu = ALU_SLT;
            default:         op_legal = 1'b0;
        endcase
    end

    always_comb begin
        id_o          = ID_EX_BUBBLE;
        legal         = 1'b0;
        id_o.valid    = 1'b1;
        id_o.pc       = if_i.pc;
        id_o.pc_next  = if_i.pc + 32'd4;
        id_o.rs1_data = rs1_data_i;
        id_o.rs2_data = rs2_data_i;
        id_o.rd       = if_i.instr[11:7];
        id_o.rs1      = rs1_o;
        id_o.rs2      = rs2_o;
        case (opcode)
            OPC_OP: begin
                legal          = op_legal;
                id_o.alu_op    = op_alu;
                id_o.reg_write = 1'b1;
            end
            OPC_OPIMM: begin
                // ADDI only
                legal             = (funct3 == 3'b000);
                id_o.imm          = imm_i;
                id_o.alu_src2_sel = SRC2_IMM;
                id_o.reg_write    = 1'b1;
            end
            OPC_LUI: begin
                legal             = 1'b1;
                id_o.imm          = imm_u;
                id_o.alu_src2_sel = SRC2_IMM;
                id_o.alu_op       = ALU_PASS_B;
                id_o.reg_write    = 1'b1;
            end
            OPC_BRANCH: begin
                // target comes out of the ALU as pc + imm
                legal             = (funct3 == 3'b000) || (funct3 == 3'b001);
                id_o.imm          = imm_b;
                id_o.branch       = 1'b1;
                id_o.cmp_op       = funct3[0] ? CMP_NE : CMP_EQ;
                id_o.alu_src1_sel = SRC1_PC;
                id_o.alu_src2_sel = SRC2_IMM;
            end
            OPC_JAL: begin
                legal             = 1'b1;
                id_o.imm          = imm_j;
                id_o.jump         = 1'b1;
                id_o.alu_src1_sel = SRC1_PC;
                id_o.alu_src2_sel = SRC2_IMM;
                id_o.reg_write    = 1'b1;
                id_o.wb_data_sel  = WB_PC4;
            end
            OPC_STORE: begin
                // SW only
                legal             = (funct3 == 3'b010);
                id_o.imm          = imm_s;
                id_o.alu_src2_sel = SRC2_IMM;
                id_o.mem_write    = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        // writes to x0 retire without a register write
        id_o.reg_write = id_o.reg_write && (id_o.rd != '0);
        if (!legal || !if_i.valid) begin
            id_o = ID_EX_BUBBLE;
        end
    end

endmodule

// File: verilog/reg_file.sv
module reg_file (
    input  logic               clk,
    input  logic               reset_i,
    input  cpu_pkg::reg_addr_t raddr1_i,
    input  cpu_pkg::reg_addr_t raddr2_i,
    output cpu_pkg::data_t     rdata1_o,
    output cpu_pkg::data_t     rdata2_o,
    input  cpu_pkg::ex_wb_t    wb_i
);

    import cpu_pkg::*;

    data_t regs [32];
    logic  we;

    // x0 is never written, so it stays at its reset value
    assign we = wb_i.valid && wb_i.reg_write && (wb_i.rd != '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wb_i.rd] <= wb_i.wdata;
        end
    end

    // same-cycle write is visible to decode
    assign rdata1_o = (we && wb_i.rd == raddr1_i) ? wb_i.wdata : regs[raddr1_i];
    assign rdata2_o = (we && wb_i.rd == raddr2_i) ? wb_i.wdata : regs[raddr2_i];

endmodule

// File: verilog/execute_unit.sv
module execute_unit (
    input  cpu_pkg::id_ex_t ex_i,
    input  cpu_pkg::ex_wb_t wb_i,
    output logic            redirect_o,
    output cpu_pkg::data_t  target_o,
    output cpu_pkg::ex_wb_t ex_o
);

    import cpu_pkg::*;

    logic  fwd_ok;
    data_t rs1_val;
    data_t rs2_val;
    data_t op_a;
    data_t op_b;
    data_t alu_res;
    data_t result;
    logic  taken;
    logic  reg_write;
    logic  mem_write;

    // writeback result bypasses the stale register read
    assign fwd_ok  = wb_i.valid && wb_i.reg_write && (wb_i.rd != '0);
    assign rs1_val = (fwd_ok && wb_i.rd == ex_i.rs1) ? wb_i.wdata : ex_i.rs1_data;
    assign rs2_val = (fwd_ok && wb_i.rd == ex_i.rs2) ? wb_i.wdata : ex_i.rs2_data;

    assign op_a = (ex_i.alu_src1_sel == SRC1_PC)  ? ex_i.pc  : rs1_val;
    assign op_b = (ex_i.alu_src2_sel == SRC2_IMM) ? ex_i.imm : rs2_val;

    always_comb begin
        case (ex_i.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // branch compare works on the forwarded register values
    always_comb begin
        case (ex_i.cmp_op)
            CMP_EQ:  taken = (rs1_val == rs2_val);
            CMP_NE:  taken = (rs1_val != rs2_val);
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o = ex_i.valid && (ex_i.jump || (ex_i.branch && taken));
    // branch and jal set up the alu as pc + imm
    assign target_o   = alu_res;

    assign reg_write = ex_i.valid && ex_i.reg_write;
    assign mem_write = ex_i.valid && ex_i.mem_write;
    assign result    = (ex_i.wb_data_sel == WB_PC4) ? ex_i.pc_next : alu_res;

    assign ex_o.valid      = ex_i.valid;
    assign ex_o.pc         = ex_i.pc;
    assign ex_o.rd         = ex_i.rd;
    assign ex_o.reg_write  = reg_write;
    assign ex_o.wdata      = reg_write ? result : '0;
    assign ex_o.mem_write  = mem_write;
    // store address is rs1 + imm from the alu
    assign ex_o.store_addr = mem_write ? alu_res : '0;
    assign ex_o.store_data = mem_write ? rs2_val : '0;

endmodule

// File: verilog/core_top.sv
module core_top #(
    parameter cpu_pkg::data_t RESET_PC = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            imem_ready_i,
    input  cpu_pkg::data_t  imem_data_i,
    output cpu_pkg::data_t  imem_addr_o,
    output cpu_pkg::retire_t commit_o
);

    import cpu_pkg::*;

    if_id_t    if_d;
    if_id_t    if_q;
    id_ex_t    id_d;
    id_ex_t    id_q;
    ex_wb_t    ex_d;
    ex_wb_t    wb_q;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    data_t     rs1_data;
    data_t     rs2_data;
    logic      redirect;
    data_t     target;
    logic      fetch_stall;
    logic      if_id_stall;
    logic      if_id_flush;
    logic      id_ex_flush;

    hazard_ctrl u_hazard (
        .imem_ready_i  (imem_ready_i),
        .redirect_i    (redirect),
        .fetch_stall_o (fetch_stall),
        .if_id_stall_o (if_id_stall),
        .if_id_flush_o (if_id_flush),
        .id_ex_flush_o (id_ex_flush)
    );

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk         (clk),
        .reset_i     (reset_i),
        .stall_i     (fetch_stall),
        .redirect_i  (redirect),
        .target_i    (target),
        .imem_data_i (imem_data_i),
        .imem_addr_o (imem_addr_o),
        .if_o        (if_d)
    );

    pipe_reg #(.payload_t(if_id_t), .BUBBLE(IF_ID_BUBBLE)) u_if_id (
        .clk     (clk),
        .reset_i (reset_i),
        .stall_i (if_id_stall),
        .flush_i (if_id_flush),
        .d_i     (if_d),
        .q_o     (if_q)
    );

    decoder u_decoder (
        .if_i       (if_q),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_o      (rs1_addr),
        .rs2_o      (rs2_addr),
        .id_o       (id_d)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .reset_i  (reset_i),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .wb_i     (wb_q)
    );

    // execute never stalls, it only sees bubbles
    pipe_reg #(.payload_t(id_ex_t), .BUBBLE(ID_EX_BUBBLE)) u_id_ex (
        .clk     (clk),
        .reset_i (reset_i),
        .stall_i (1'b0),
        .flush_i (id_ex_flush),
        .d_i     (id_d),
        .q_o     (id_q)
    );

    execute_unit u_execute (
        .ex_i       (id_q),
        .wb_i       (wb_q),
        .redirect_o (redirect),
        .target_o   (target),
        .ex_o       (ex_d)
    );

    pipe_reg #(.payload_t(ex_wb_t), .BUBBLE(EX_WB_BUBBLE)) u_ex_wb (
        .clk     (clk),
        .reset_i (reset_i),
        .stall_i (1'b0),
        .flush_i (1'b0),
        .d_i     (ex_d),
        .q_o     (wb_q)
    );

    assign commit_o = wb_q;

endmodule

// File: verification/core_sva.sv
module core_sva (
    input logic             clk,
    input logic             reset_i,
    input cpu_pkg::retire_t commit_i,
    input logic             redirect_i,
    input logic             id_ex_valid_i
);

    int unsigned fail_count = 0;

    // writes to x0 are dropped before retirement
    a_no_x0_write: assert property (@(posedge clk) disable iff (reset_i)
        commit_i.valid && commit_i.reg_write |-> commit_i.rd != '0)
    else begin
        fail_count++;
        $error("commit with reg_write set and rd equal to x0");
    end

    a_quiet_in_reset: assert property (@(posedge clk)
        reset_i |=> !commit_i.valid)
    else begin
        fail_count++;
        $error("commit valid while reset is high");
    end

    // wrong-path slot behind a taken branch or jump
    a_flush_on_redirect: assert property (@(posedge clk) disable iff (reset_i)
        redirect_i |=> !id_ex_valid_i)
    else begin
        fail_count++;
        $error("execute stage valid in the cycle after a redirect");
    end

endmodule

bind core_top core_sva u_sva (
    .clk           (clk),
    .reset_i       (reset_i),
    .commit_i      (commit_o),
    .redirect_i    (redirect),
    .id_ex_valid_i (id_q.valid)
);

// File: verification/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// one generated instruction, kept at the ISA level
typedef enum logic [3:0] {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_ADDI, K_LUI, K_BEQ, K_BNE, K_JAL, K_SW
} kind_t;

typedef struct packed {
    kind_t     kind;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    data_t     imm;
} insn_t;

data_t ref_regs [32];
data_t ref_pc;

task automatic ref_reset(input data_t start_pc);
    ref_pc = start_pc;
    foreach (ref_regs[i]) begin
        ref_regs[i] = '0;
    end
endtask

// execute one instruction and predict its retire record
task automatic ref_step(input insn_t in, output retire_t exp);
    data_t a;
    data_t b;
    data_t res;
    logic  wr;
    a         = ref_regs[in.rs1];
    b         = ref_regs[in.rs2];
    res       = '0;
    wr        = 1'b1;
    exp       = '0;
    exp.valid = 1'b1;
    exp.pc    = ref_pc;
    exp.rd    = in.rd;
    ref_pc    = ref_pc + 32'd4;
    case (in.kind)
        K_ADD:  res = a + b;
        K_SUB:  res = a - b;
        K_AND:  res = a & b;
        K_OR:   res = a | b;
        K_XOR:  res = a ^ b;
        K_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        K_ADDI: res = a + in.imm;
        K_LUI:  res = in.imm;
        K_JAL: begin
            // link is the address after the jump
            res    = exp.pc + 32'd4;
            ref_pc = exp.pc + in.imm;
        end
        K_BEQ, K_BNE: begin
            wr = 1'b0;
            if ((a == b) == (in.kind == K_BEQ)) begin
                ref_pc = exp.pc + in.imm;
            end
        end
        K_SW: begin
            wr             = 1'b0;
            exp.mem_write  = 1'b1;
            exp.store_addr = a + in.imm;
            exp.store_data = b;
        end
        default: wr = 1'b0;
    endcase
    // x0 stays zero
    if (wr && in.rd != '0) begin
        exp.reg_write   = 1'b1;
        exp.wdata       = res;
        ref_regs[in.rd] = res;
    end
endtask

`endif

// File: verification/core_tb.sv
module core_tb;

    import cpu_pkg::*;

    `include "rv_ref_model.svh"

    localparam data_t RESET_PC       = 32'h0000_0200;
    localparam int    PROG_WORDS     = 64;
    localparam int    NUM_COMMITS    = 2000;
    localparam int    COMMIT_TIMEOUT = 200;
    localparam int    SEED           = 32'ha3adc579;

    logic    clk;
    logic    reset_i;
    logic    imem_ready_i;
    data_t   imem_data_i;
    data_t   imem_addr_o;
    retire_t commit_o;

    insn_t prog [PROG_WORDS];
    int    errors;
    int    checks;
    int    commits;
    bit    timed_out;

    core_top #(.RESET_PC(RESET_PC)) dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .imem_ready_i (imem_ready_i),
        .imem_data_i  (imem_data_i),
        .imem_addr_o  (imem_addr_o),
        .commit_o     (commit_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // RV32I encodings from the ISA manual
    function automatic data_t encode(input insn_t in);
        data_t im;
        im = in.imm;
        case (in.kind)
            K_ADD:   return {7'b0000000, in.rs2, in.rs1, 3'b000, in.rd, OPC_OP};
            K_SUB:   return {7'b0100000, in.rs2, in.rs1, 3'b000, in.rd, OPC_OP};
            K_AND:   return {7'b0000000, in.rs2, in.rs1, 3'b111, in.rd, OPC_OP};
            K_OR:    return {7'b0000000, in.rs2, in.rs1, 3'b110, in.rd, OPC_OP};
            K_XOR:   return {7'b0000000, in.rs2, in.rs1, 3'b100, in.rd, OPC_OP};
            K_SLT:   return {7'b0000000, in.rs2, in.rs1, 3'b010, in.rd, OPC_OP};
            K_ADDI:  return {im[11:0], in.rs1, 3'b000, in.rd, OPC_OPIMM};
            K_LUI:   return {im[31:12], in.rd, OPC_LUI};
            K_BEQ:   return {im[12], im[10:5], in.rs2, in.rs1, 3'b000, im[4:1], im[11], OPC_BRANCH};
            K_BNE:   return {im[12], im[10:5], in.rs2, in.rs1, 3'b001, im[4:1], im[11], OPC_BRANCH};
            K_JAL:   return {im[20], im[10:1], im[11], im[19:12], in.rd, OPC_JAL};
            K_SW:    return {im[11:5], in.rs2, in.rs1, 3'b010, im[4:0], OPC_STORE};
            default: return 32'h0000_0013;
        endcase
    endfunction

    // addi x0, x0, 0 outside the program
    function automatic insn_t insn_at(input data_t pc);
        data_t off;
        insn_t nop;
        off      = pc - RESET_PC;
        nop      = '0;
        nop.kind = K_ADDI;
        if (off < PROG_WORDS * 4) begin
            return prog[off[31:2]];
        end
        return nop;
    endfunction

    // branches and jumps only go forward, the last word jumps back to the start
    task automatic gen_program();
        insn_t in;
        data_t r;
        int    target;
        for (int i = 0; i < PROG_WORDS; i++) begin
            r       = $urandom;
            in.kind = kind_t'($urandom % 12);
            in.rd   = reg_addr_t'($urandom % 8);
            in.rs1  = reg_addr_t'($urandom % 8);
            in.rs2  = reg_addr_t'($urandom % 8);
            in.imm  = {{20{r[11]}}, r[11:0]};
            if (i == PROG_WORDS - 1) begin
                in.kind = K_JAL;
                in.imm  = data_t'(-(i * 4));
            end else if (in.kind inside {K_BEQ, K_BNE, K_JAL}) begin
                target = i + 1 + int'($urandom % (PROG_WORDS - 1 - i));
                in.imm = data_t'((target - i) * 4);
            end else if (in.kind == K_LUI) begin
                in.imm = {r[31:12], 12'b0};
            end
            prog[i] = in;
        end
    endtask

    always_comb begin
        imem_data_i = encode(insn_at({imem_addr_o[29:0], 2'b00}));
    end

    // memory is ready about three cycles in four
    always @(negedge clk) begin
        imem_ready_i = ($urandom % 4) != 0;
    end

    task automatic report_mismatch(input string name, input string field,
                                   input data_t exp, input data_t act);
        errors++;
        $display("mismatch %s %s: expected %h, actual %h", name, field, exp, act);
    endtask

    task automatic compare(input string name, input retire_t exp, input retire_t act);
        checks++;
        assert (act.pc === exp.pc) else report_mismatch(name, "pc", exp.pc, act.pc);
        assert (act.reg_write === exp.reg_write)
            else report_mismatch(name, "reg_write", exp.reg_write, act.reg_write);
        assert (act.mem_write === exp.mem_write)
            else report_mismatch(name, "mem_write", exp.mem_write, act.mem_write);
        if (exp.reg_write) begin
            assert (act.rd === exp.rd) else report_mismatch(name, "rd", exp.rd, act.rd);
            assert (act.wdata === exp.wdata)
                else report_mismatch(name, "wdata", exp.wdata, act.wdata);
        end
        if (exp.mem_write) begin
            assert (act.store_addr === exp.store_addr)
                else report_mismatch(name, "store_addr", exp.store_addr, act.store_addr);
            assert (act.store_data === exp.store_data)
                else report_mismatch(name, "store_data", exp.store_data, act.store_data);
        end
    endtask

    // commit port is sampled mid-cycle, once per cycle
    task automatic wait_commit(output bit seen);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (commit_o.valid !== 1'b1 && cycles < COMMIT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        seen = (commit_o.valid === 1'b1);
    endtask

    initial begin
        retire_t exp;
        insn_t   in;
        bit      seen;
        void'($urandom(SEED));
        reset_i      = 1'b1;
        imem_ready_i = 1'b0;
        errors       = 0;
        checks       = 0;
        commits      = 0;
        timed_out    = 1'b0;
        gen_program();
        ref_reset(RESET_PC);
        repeat (3) begin
            @(negedge clk);
            assert (commit_o.valid === 1'b0) else begin
                errors++;
                $display("commit port valid while reset is high");
            end
        end
        reset_i = 1'b0;
        while (commits < NUM_COMMITS && !timed_out) begin
            wait_commit(seen);
            if (!seen) begin
                timed_out = 1'b1;
                errors++;
                $display("no commit within %0d cycles", COMMIT_TIMEOUT);
            end else begin
                in = insn_at(ref_pc);
                ref_step(in, exp);
                if (commits == 0) begin
                    assert (commit_o.pc === RESET_PC)
                        else report_mismatch("first commit", "pc", RESET_PC, commit_o.pc);
                end
                compare($sformatf("%s #%0d", in.kind.name(), commits), exp, commit_o);
                commits++;
            end
        end
        errors += int'(dut.u_sva.fail_count);
        $display("commits %0d, checks %0d, errors %0d (assertion failures %0d)",
                 commits, checks, errors, dut.u_sva.fail_count);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+verification
verilog/cpu_pkg.sv
verilog/pipe_reg.sv
verilog/fetch_unit.sv
verilog/hazard_ctrl.sv
verilog/decoder.sv
verilog/reg_file.sv
verilog/execute_unit.sv
verilog/core_top.sv
verification/core_sva.sv
verification/core_tb.sv

// File: Bender.yml
package:
  name: rv32i_core

sources:
  - files:
      - verilog/cpu_pkg.sv
      - verilog/pipe_reg.sv
      - verilog/fetch_unit.sv
      - verilog/hazard_ctrl.sv
      - verilog/decoder.sv
      - verilog/reg_file.sv
      - verilog/execute_unit.sv
      - verilog/core_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/core_sva.sv
      - verification/core_tb.sv
